// ==== compile.f ====
src/pm_pkg.sv
src/iq_power_acc.sv
src/rx_source_sel.sv
src/meter_bank.sv
src/result_arb.sv
src/result_ram.sv
src/power_meter_top.sv
test/power_meter_asserts.sv
test/tb_power_meter.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_power_meter
FILELIST  := compile.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Finished with errors

SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qx "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/tb_power_meter.sv ====
`timescale 1ns/1ps

module tb_power_meter;

   localparam logic [31:0] seed     = 32'h4aa0_2145;
   localparam int          period   = 100;
   localparam int          max_wait = 200;  // cycles per busy wait

   logic                                 clk_3x;
   logic                                 rst_n;
   pm_pkg::dac_iq_t [pm_pkg::n_ant-1:0]  dac_data;
   logic [pm_pkg::n_ant-1:0]             dac_valid;
   pm_pkg::rx_iq_t [pm_pkg::n_ant-1:0]   ul_data;
   logic [pm_pkg::n_ant-1:0]             ul_valid;
   pm_pkg::rx_iq_t [pm_pkg::n_ant-1:0]   srx_data;
   logic [pm_pkg::n_ant-1:0]             srx_valid;
   logic                                 rssi_load;
   logic                                 pa_tssi_load;
   logic                                 rx_tx_mode_sel;
   logic                                 sync_5ms;
   logic                                 debug_override;
   logic [pm_pkg::addr_w-1:0]            rd_addr;
   logic [pm_pkg::pwr_w-1:0]             rd_data;
   logic                                 busy;

   logic [31:0] rng;
   logic        cur_sel;
   logic        cur_sync;
   logic        cur_dbg;
   int          n_tests;
   int          n_checks;
   int          n_errors;

   //////////////////////////////
   // reference model state

   logic [31:0] acc_tssi [pm_pkg::n_ant];
   logic [31:0] acc_pa   [pm_pkg::n_ant];
   logic [31:0] acc_rx   [pm_pkg::n_ant];
   logic [63:0] pipe_e   [pm_pkg::n_ant];  // rx energy one cycle behind
   logic [31:0] exp_mem  [16];

   power_meter_top i_power_meter_top (.*);

   bind result_arb power_meter_asserts i_power_meter_asserts (.*);

   initial begin
      clk_3x = 1'b0;
      forever #(period / 2) clk_3x = ~clk_3x;
   end

   function automatic logic [31:0] next_rand();
      rng ^= rng << 13;
      rng ^= rng >> 17;
      rng ^= rng << 5;
      return rng;
   endfunction

   function automatic logic [63:0] iq_energy(input int i, input int q);
      return 64'(i * i) + 64'(q * q);
   endfunction

   function automatic logic [31:0] sat_add(input logic [31:0] acc, input logic [63:0] e);
      logic [63:0] s;
      s = {32'd0, acc} + e;
      return (s[63:32] != 32'd0) ? 32'hFFFF_FFFF : s[31:0];
   endfunction

   //////////////////////////////
   // one clock of stimulus plus the model step

   task automatic drive_cycle(input bit en, input bit full, input bit rl, input bit pl);
      pm_pkg::dac_iq_t [pm_pkg::n_ant-1:0] dd;
      pm_pkg::rx_iq_t [pm_pkg::n_ant-1:0]  ud;
      pm_pkg::rx_iq_t [pm_pkg::n_ant-1:0]  sd;
      logic [31:0] r;
      logic [3:0]  dv;
      logic [3:0]  uv;
      logic [3:0]  sv;
      logic        md;
      logic [31:0] t;
      int          act;
      int          off;
      r  = next_rand();
      dv = (full ? 4'hf : r[3:0]) & {4{en}};
      uv = (full ? 4'hf : r[7:4]) & {4{en}};
      sv = (full ? 4'hf : r[11:8]) & {4{en}};
      for (int a = 0; a < pm_pkg::n_ant; a++) begin
         r = next_rand();
         dd[a].i = full ? 16'h8000 : r[15:0];  // most negative is full scale
         dd[a].q = full ? 16'h8000 : r[31:16];
         r = next_rand();
         ud[a].i = full ? 14'h2000 : r[13:0];
         ud[a].q = full ? 14'h2000 : r[27:14];
         r = next_rand();
         sd[a].i = full ? 14'h2000 : r[13:0];
         sd[a].q = full ? 14'h2000 : r[27:14];
      end
      @(posedge clk_3x);
      dac_data       <= dd;
      dac_valid      <= dv;
      ul_data        <= ud;
      ul_valid       <= uv;
      srx_data       <= sd;
      srx_valid      <= sv;
      rssi_load      <= rl;
      pa_tssi_load   <= pl;
      rx_tx_mode_sel <= cur_sel;
      sync_5ms       <= cur_sync;
      debug_override <= cur_dbg;
      md  = cur_dbg ? cur_sync : cur_sel;
      act = md ? int'(pm_pkg::base_orx) : int'(pm_pkg::base_ul);
      off = md ? int'(pm_pkg::base_ul) : int'(pm_pkg::base_orx);
      for (int a = 0; a < pm_pkg::n_ant; a++) begin
         t = sat_add(acc_tssi[a], dv[a] ? iq_energy(int'(dd[a].i), int'(dd[a].q)) : 64'd0);
         if (rl) begin
            exp_mem[int'(pm_pkg::base_tssi) + a] = t;
         end
         acc_tssi[a] = rl ? 32'd0 : t;
         t = sat_add(acc_pa[a], dv[a] ? iq_energy(int'(dd[a].i), int'(dd[a].q)) : 64'd0);
         if (pl) begin
            exp_mem[int'(pm_pkg::base_pa_tssi) + a] = t;
         end
         acc_pa[a] = pl ? 32'd0 : t;
         t = sat_add(acc_rx[a], pipe_e[a]);
         if (rl) begin
            exp_mem[act + a] = t;
            exp_mem[off + a] = 32'd0;  // idle region cleared
         end
         acc_rx[a] = rl ? 32'd0 : t;
         if (md) begin
            pipe_e[a] = sv[a] ? iq_energy(int'(sd[a].i), int'(sd[a].q)) : 64'd0;
         end else begin
            pipe_e[a] = uv[a] ? iq_energy(int'(ud[a].i), int'(ud[a].q)) : 64'd0;
         end
      end
   endtask

   task automatic wait_idle(input string name);
      int cnt;
      cnt = 0;
      @(negedge clk_3x);
      while (!busy && cnt < max_wait) begin  // posting starts two edges after the load
         drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
         @(negedge clk_3x);
         cnt++;
      end
      n_checks++;
      assert (busy) else begin
         $display("%s: busy never rose after the load", name);
         n_errors++;
      end
      cnt = 0;
      while (busy && cnt < max_wait) begin
         drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
         @(negedge clk_3x);
         cnt++;
      end
      n_checks++;
      assert (!busy) else begin
         $display("%s: busy still high after %0d cycles", name, max_wait);
         n_errors++;
      end
   endtask

   task automatic read_all(input string name);
      for (int k = 0; k < 16; k++) begin
         @(posedge clk_3x);
         rd_addr <= 4'(k);
         @(negedge clk_3x);
         @(negedge clk_3x);
         n_checks++;
         assert (rd_data == exp_mem[k]) else begin
            $display("error %s addr %0d expected %h actual %h", name, k, exp_mem[k], rd_data);
            n_errors++;
         end
      end
   endtask

   task automatic run_window(input string name, input int len, input int pa_at, input bit full);
      for (int c = 0; c < len; c++) begin
         drive_cycle(1'b1, full, c == len - 1, c == pa_at);
      end
      wait_idle(name);
      read_all(name);
   endtask

   task automatic report_test(input string name, input int e0);
      n_tests++;
      $display("test %s: %0d errors", name, n_errors - e0);
   endtask

   //////////////////////////////
   // directed tests

   task automatic test_reset_state();
      int e0;
      e0 = n_errors;
      @(negedge clk_3x);
      n_checks++;
      assert (!busy) else begin
         $display("error reset_state busy expected 0 actual %b", busy);
         n_errors++;
      end
      read_all("reset_state");
      report_test("reset_state", e0);
   endtask

   task automatic test_tssi_windows();
      int e0;
      e0 = n_errors;
      run_window("tssi_windows", 24, 9, 1'b0);
      run_window("tssi_windows", 20, 4, 1'b0);
      report_test("tssi_windows", e0);
   endtask

   task automatic test_rx_modes();
      int e0;
      e0 = n_errors;
      cur_sel = 1'b0;
      run_window("rx_uplink", 16, 3, 1'b0);
      cur_sel = 1'b1;
      run_window("rx_srx", 16, 7, 1'b0);
      cur_sel = 1'b0;
      report_test("rx_modes", e0);
   endtask

   task automatic test_override();
      int e0;
      e0 = n_errors;
      cur_dbg  = 1'b1;
      cur_sel  = 1'b1;  // ignored while overridden
      cur_sync = 1'b0;
      run_window("override_ul", 18, 5, 1'b0);
      cur_sel  = 1'b0;
      cur_sync = 1'b1;
      run_window("override_orx", 18, 11, 1'b0);
      cur_dbg  = 1'b0;
      cur_sync = 1'b0;
      report_test("override", e0);
   endtask

   task automatic test_saturation();
      int e0;
      e0 = n_errors;
      run_window("saturation", 40, 39, 1'b1);  // both loads in one cycle
      run_window("contention", 20, 19, 1'b0);
      report_test("saturation", e0);
   endtask

   initial begin
      rst_n          = 1'b0;
      dac_data       = '0;
      dac_valid      = '0;
      ul_data        = '0;
      ul_valid       = '0;
      srx_data       = '0;
      srx_valid      = '0;
      rssi_load      = 1'b0;
      pa_tssi_load   = 1'b0;
      rx_tx_mode_sel = 1'b0;
      sync_5ms       = 1'b0;
      debug_override = 1'b0;
      rd_addr        = '0;
      rng            = seed;
      cur_sel        = 1'b0;
      cur_sync       = 1'b0;
      cur_dbg        = 1'b0;
      n_tests        = 0;
      n_checks       = 0;
      n_errors       = 0;
      acc_tssi       = '{default: '0};
      acc_pa         = '{default: '0};
      acc_rx         = '{default: '0};
      pipe_e         = '{default: '0};
      exp_mem        = '{default: '0};
      repeat (4) @(posedge clk_3x);
      rst_n <= 1'b1;
      test_reset_state();
      test_tssi_windows();
      test_rx_modes();
      test_override();
      test_saturation();
      $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// ==== test/power_meter_asserts.sv ====
`timescale 1ns/1ps

module power_meter_asserts (
   input logic                      clk_3x,
   input logic                      rst_n,
   input logic [pm_pkg::n_bank-1:0] req,
   input logic [pm_pkg::n_bank-1:0] gnt,
   input logic                      we,
   input logic [pm_pkg::addr_w-1:0] waddr
);

   //////////////////////////////
   // arbiter grant rules

   grant_onehot: assert property (@(posedge clk_3x) disable iff (!rst_n)
      $onehot0(gnt))
      else $error("more than one bank granted");

   grant_to_req: assert property (@(posedge clk_3x) disable iff (!rst_n)
      (gnt & ~req) == '0)
      else $error("grant to a bank without a request");

   // pending request holds until its grant
   req_held: assert property (@(posedge clk_3x) disable iff (!rst_n)
      (|(req & ~gnt)) |=> ((req & $past(req & ~gnt)) == $past(req & ~gnt)))
      else $error("request dropped before grant");

   // a write lands in the region of the granted bank
   write_needs_gnt: assert property (@(posedge clk_3x) disable iff (!rst_n)
      we |-> ((gnt[0] && waddr < pm_pkg::base_pa_tssi)
           || (gnt[1] && waddr >= pm_pkg::base_pa_tssi && waddr < pm_pkg::base_ul)
           || (gnt[2] && waddr >= pm_pkg::base_ul)))
      else $error("memory write without a grant or outside the granted bank's region");

endmodule

// ==== src/power_meter_top.sv ====
`timescale 1ns/1ps

module power_meter_top (
   input  logic                                  clk_3x,
   input  logic                                  rst_n,
   input  pm_pkg::dac_iq_t [pm_pkg::n_ant-1:0]   dac_data,
   input  logic [pm_pkg::n_ant-1:0]              dac_valid,
   input  pm_pkg::rx_iq_t [pm_pkg::n_ant-1:0]    ul_data,
   input  logic [pm_pkg::n_ant-1:0]              ul_valid,
   input  pm_pkg::rx_iq_t [pm_pkg::n_ant-1:0]    srx_data,
   input  logic [pm_pkg::n_ant-1:0]              srx_valid,
   input  logic                                  rssi_load,
   input  logic                                  pa_tssi_load,
   input  logic                                  rx_tx_mode_sel,
   input  logic                                  sync_5ms,
   input  logic                                  debug_override,
   input  logic [pm_pkg::addr_w-1:0]             rd_addr,
   output logic [pm_pkg::pwr_w-1:0]              rd_data,
   output logic                                  busy
);

   pm_pkg::rx_iq_t [pm_pkg::n_ant-1:0]          sel_data;
   logic [pm_pkg::n_ant-1:0]                    sel_valid;
   logic                                        rx_mode;
   logic [pm_pkg::n_bank-1:0]                   req;
   logic [pm_pkg::n_bank-1:0]                   gnt;
   logic [pm_pkg::n_bank-1:0]                   bank_busy;
   logic [pm_pkg::n_bank-1:0][pm_pkg::addr_w-1:0] wr_addr;
   logic [pm_pkg::n_bank-1:0][pm_pkg::pwr_w-1:0]  wr_data;
   logic                                        we;
   logic [pm_pkg::addr_w-1:0]                   waddr;
   logic [pm_pkg::pwr_w-1:0]                    wdata;

   rx_source_sel i_rx_source_sel (
      .clk_3x         (clk_3x),
      .rst_n          (rst_n),
      .rx_tx_mode_sel (rx_tx_mode_sel),
      .sync_5ms       (sync_5ms),
      .debug_override (debug_override),
      .ul_data        (ul_data),
      .ul_valid       (ul_valid),
      .srx_data       (srx_data),
      .srx_valid      (srx_valid),
      .sel_data       (sel_data),
      .sel_valid      (sel_valid),
      .rx_mode        (rx_mode)
   );

   //////////////////////////////
   // measurement banks

   meter_bank #(
      .sample_t (pm_pkg::dac_iq_t),
      .base     (pm_pkg::base_tssi),
      .alt_base (pm_pkg::base_tssi),
      .dual     (1'b0)
   ) i_tssi_bank (
      .clk_3x  (clk_3x),
      .rst_n   (rst_n),
      .data    (dac_data),
      .valid   (dac_valid),
      .load    (rssi_load),
      .region  (1'b0),
      .req     (req[0]),
      .gnt     (gnt[0]),
      .wr_addr (wr_addr[0]),
      .wr_data (wr_data[0]),
      .busy    (bank_busy[0])
   );

   meter_bank #(
      .sample_t (pm_pkg::dac_iq_t),
      .base     (pm_pkg::base_pa_tssi),
      .alt_base (pm_pkg::base_pa_tssi),
      .dual     (1'b0)
   ) i_pa_tssi_bank (
      .clk_3x  (clk_3x),
      .rst_n   (rst_n),
      .data    (dac_data),
      .valid   (dac_valid),
      .load    (pa_tssi_load),  // own strobe on the same dac stream
      .region  (1'b0),
      .req     (req[1]),
      .gnt     (gnt[1]),
      .wr_addr (wr_addr[1]),
      .wr_data (wr_data[1]),
      .busy    (bank_busy[1])
   );

   meter_bank #(
      .sample_t (pm_pkg::rx_iq_t),
      .base     (pm_pkg::base_ul),
      .alt_base (pm_pkg::base_orx),
      .dual     (1'b1)
   ) i_rx_bank (
      .clk_3x  (clk_3x),
      .rst_n   (rst_n),
      .data    (sel_data),
      .valid   (sel_valid),
      .load    (rssi_load),
      .region  (rx_mode),  // 1 selects orx
      .req     (req[2]),
      .gnt     (gnt[2]),
      .wr_addr (wr_addr[2]),
      .wr_data (wr_data[2]),
      .busy    (bank_busy[2])
   );

   //////////////////////////////
   // shared result memory

   result_arb i_result_arb (
      .clk_3x  (clk_3x),
      .rst_n   (rst_n),
      .req     (req),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .gnt     (gnt),
      .we      (we),
      .waddr   (waddr),
      .wdata   (wdata)
   );

   result_ram i_result_ram (
      .clk_3x  (clk_3x),
      .rst_n   (rst_n),
      .we      (we),
      .waddr   (waddr),
      .wdata   (wdata),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   assign busy = |bank_busy;

endmodule

// ==== src/result_ram.sv ====
`timescale 1ns/1ps

module result_ram (
   input  logic                      clk_3x,
   input  logic                      rst_n,
   input  logic                      we,
   input  logic [pm_pkg::addr_w-1:0] waddr,
   input  logic [pm_pkg::pwr_w-1:0]  wdata,
   input  logic [pm_pkg::addr_w-1:0] rd_addr,
   output logic [pm_pkg::pwr_w-1:0]  rd_data
);

   localparam int depth = 2 ** pm_pkg::addr_w;

   logic [pm_pkg::pwr_w-1:0] mem [depth];

   // reads before any window must return zero
   always_ff @(posedge clk_3x or negedge rst_n) begin
      if (!rst_n) begin
         for (int k = 0; k < depth; k++) begin
            mem[k] <= '0;
         end
      end else if (we) begin
         mem[waddr] <= wdata;
      end
   end

   always_ff @(posedge clk_3x or negedge rst_n) begin
      if (!rst_n) begin
         rd_data <= '0;
      end else begin
         rd_data <= mem[rd_addr];  // one cycle read
      end
   end

endmodule

// ==== src/result_arb.sv ====
`timescale 1ns/1ps

module result_arb (
   input  logic                                           clk_3x,
   input  logic                                           rst_n,
   input  logic [pm_pkg::n_bank-1:0]                      req,
   input  logic [pm_pkg::n_bank-1:0][pm_pkg::addr_w-1:0]  wr_addr,
   input  logic [pm_pkg::n_bank-1:0][pm_pkg::pwr_w-1:0]   wr_data,
   output logic [pm_pkg::n_bank-1:0]                      gnt,
   output logic                                           we,
   output logic [pm_pkg::addr_w-1:0]                      waddr,
   output logic [pm_pkg::pwr_w-1:0]                       wdata
);

   localparam int idx_w = $clog2(pm_pkg::n_bank);

   logic [idx_w-1:0] ptr;
   logic [idx_w-1:0] g_idx;

   //////////////////////////////
   // grant to the first requester from ptr

   always_comb begin
      logic found;
      int   idx;
      gnt   = '0;
      g_idx = '0;
      found = 1'b0;
      for (int k = 0; k < pm_pkg::n_bank; k++) begin
         idx = (int'(ptr) + k) % pm_pkg::n_bank;
         if (!found && req[idx]) begin
            gnt[idx] = 1'b1;
            g_idx    = idx_w'(idx);
            found    = 1'b1;
         end
      end
   end

   always_ff @(posedge clk_3x or negedge rst_n) begin
      if (!rst_n) begin
         ptr <= '0;
      end else if (|gnt) begin
         // move past the winner
         ptr <= (int'(g_idx) == pm_pkg::n_bank - 1) ? '0 : g_idx + 1'b1;
      end
   end

   assign we    = |gnt;
   assign waddr = wr_addr[g_idx];
   assign wdata = wr_data[g_idx];

endmodule

// ==== src/meter_bank.sv ====
`timescale 1ns/1ps

module meter_bank #(
   parameter type                       sample_t = pm_pkg::dac_iq_t,
   parameter logic [pm_pkg::addr_w-1:0] base     = pm_pkg::base_tssi,
   parameter logic [pm_pkg::addr_w-1:0] alt_base = pm_pkg::base_tssi,
   parameter bit                        dual     = 1'b0
) (
   input  logic                              clk_3x,
   input  logic                              rst_n,
   input  sample_t [pm_pkg::n_ant-1:0]       data,
   input  logic [pm_pkg::n_ant-1:0]          valid,
   input  logic                              load,
   input  logic                              region,
   output logic                              req,
   input  logic                              gnt,
   output logic [pm_pkg::addr_w-1:0]         wr_addr,
   output logic [pm_pkg::pwr_w-1:0]          wr_data,
   output logic                              busy
);

   localparam int         n_wr     = dual ? 2 * pm_pkg::n_ant : pm_pkg::n_ant;
   localparam logic [2:0] last_idx = 3'(n_wr - 1);

   logic [pm_pkg::n_ant-1:0][pm_pkg::pwr_w-1:0] power;
   logic [pm_pkg::n_ant-1:0]                    stb;
   logic [pm_pkg::n_ant-1:0][pm_pkg::pwr_w-1:0] pwr_q;
   logic                                        region_q;
   logic [2:0]                                  wr_idx;
   logic [1:0]                                  ant;
   logic                                        clear_half;
   logic [pm_pkg::addr_w-1:0]                   act_base;
   logic [pm_pkg::addr_w-1:0]                   off_base;

   for (genvar a = 0; a < pm_pkg::n_ant; a++) begin : g_acc
      iq_power_acc #(
         .sample_t   (sample_t)
      ) i_iq_power_acc (
         .clk_3x     (clk_3x),
         .rst_n      (rst_n),
         .valid      (valid[a]),
         .data       (data[a]),
         .load       (load),
         .power      (power[a]),
         .result_stb (stb[a])
      );
   end

   //////////////////////////////
   // capture and write sequencer

   always_ff @(posedge clk_3x) begin
      if (|stb) begin
         pwr_q    <= power;
         region_q <= region;
      end
   end

   always_ff @(posedge clk_3x or negedge rst_n) begin
      if (!rst_n) begin
         busy   <= 1'b0;
         wr_idx <= '0;
      end else if (|stb) begin
         busy   <= 1'b1;  // restart drops older results
         wr_idx <= '0;
      end else if (busy && gnt) begin
         if (wr_idx == last_idx) begin
            busy <= 1'b0;
         end
         wr_idx <= wr_idx + 3'd1;
      end
   end

   assign req = busy;

   // second half of a dual sequence zeroes the idle region
   assign ant        = wr_idx[1:0];
   assign clear_half = dual && wr_idx[2];
   assign act_base   = (dual && region_q) ? alt_base : base;
   assign off_base   = (dual && region_q) ? base : alt_base;

   assign wr_addr = (clear_half ? off_base : act_base) + {2'b00, ant};
   assign wr_data = clear_half ? '0 : pwr_q[ant];

endmodule

// ==== src/rx_source_sel.sv ====
`timescale 1ns/1ps

module rx_source_sel (
   input  logic                                     clk_3x,
   input  logic                                     rst_n,
   input  logic                                     rx_tx_mode_sel,
   input  logic                                     sync_5ms,
   input  logic                                     debug_override,
   input  pm_pkg::rx_iq_t [pm_pkg::n_ant-1:0]       ul_data,
   input  logic [pm_pkg::n_ant-1:0]                 ul_valid,
   input  pm_pkg::rx_iq_t [pm_pkg::n_ant-1:0]       srx_data,
   input  logic [pm_pkg::n_ant-1:0]                 srx_valid,
   output pm_pkg::rx_iq_t [pm_pkg::n_ant-1:0]       sel_data,
   output logic [pm_pkg::n_ant-1:0]                 sel_valid,
   output logic                                     rx_mode
);

   logic mode;

   // frame sync takes over in debug
   assign mode = debug_override ? sync_5ms : rx_tx_mode_sel;

   always_ff @(posedge clk_3x or negedge rst_n) begin
      if (!rst_n) begin
         sel_valid <= '0;
         rx_mode   <= 1'b0;
      end else begin
         sel_valid <= mode ? srx_valid : ul_valid;
         rx_mode   <= mode;  // stays aligned with sel_data
      end
   end

   always_ff @(posedge clk_3x) begin
      sel_data <= mode ? srx_data : ul_data;
   end

endmodule

// ==== src/iq_power_acc.sv ====
`timescale 1ns/1ps

module iq_power_acc #(
   parameter type sample_t = pm_pkg::dac_iq_t
) (
   input  logic                     clk_3x,
   input  logic                     rst_n,
   input  logic                     valid,
   input  sample_t                  data,
   input  logic                     load,
   output logic [pm_pkg::pwr_w-1:0] power,
   output logic                     result_stb
);

   localparam int comp_w = $bits(sample_t) / 2;
   localparam int sq_w   = 2 * comp_w;
   localparam int sum_w  = pm_pkg::pwr_w + 1;

   logic signed [comp_w-1:0]   s_i;
   logic signed [comp_w-1:0]   s_q;
   logic signed [sq_w-1:0]     sq_i;
   logic signed [sq_w-1:0]     sq_q;
   logic [sq_w:0]              mag;
   logic [sum_w-1:0]           sum_wide;
   logic [pm_pkg::pwr_w-1:0]   acc;
   logic [pm_pkg::pwr_w-1:0]   acc_next;

   assign s_i  = data.i;
   assign s_q  = data.q;
   assign sq_i = s_i * s_i;
   assign sq_q = s_q * s_q;
   assign mag  = {1'b0, sq_i} + {1'b0, sq_q};  // never negative

   //////////////////////////////
   // window sum with saturation

   assign sum_wide = {1'b0, acc} + sum_w'(mag);

   always_comb begin
      if (!valid) begin
         acc_next = acc;
      end else if (sum_wide[pm_pkg::pwr_w]) begin
         acc_next = '1;  // clamp at full scale
      end else begin
         acc_next = sum_wide[pm_pkg::pwr_w-1:0];
      end
   end

   always_ff @(posedge clk_3x or negedge rst_n) begin
      if (!rst_n) begin
         acc        <= '0;
         result_stb <= 1'b0;
      end else begin
         acc        <= load ? '0 : acc_next;  // new window starts after load
         result_stb <= load;
      end
   end

   // closing sum includes the load cycle's sample
   always_ff @(posedge clk_3x) begin
      if (load) begin
         power <= acc_next;
      end
   end

endmodule

// ==== src/pm_pkg.sv ====
package pm_pkg;

   //////////////////////////////
   // sizes

   localparam int n_ant  = 4;
   localparam int n_bank = 3;
   localparam int pwr_w  = 32;
   localparam int addr_w = 4;

   //////////////////////////////
   // result memory map

   localparam logic [addr_w-1:0] base_tssi    = 4'd0;   // one dl tssi word per antenna
   localparam logic [addr_w-1:0] base_pa_tssi = 4'd4;   // pa observation tssi
   localparam logic [addr_w-1:0] base_ul      = 4'd8;   // uplink wrssi
   localparam logic [addr_w-1:0] base_orx     = 4'd12;  // srx wrssi

   //////////////////////////////
   // sample formats

   // dac stream with i in the upper half
   typedef struct packed {
      logic signed [15:0] i;
      logic signed [15:0] q;
   } dac_iq_t;

   // uplink and srx streams
   typedef struct packed {
      logic signed [13:0] i;
      logic signed [13:0] q;
   } rx_iq_t;

endpackage
